// ==== hdl/fsa.sv ====
`timescale 1ns/10ps
`default_nettype none

module fsa (
	input  wire clk,
	input  wire resetn,

	input  wire fsa_pkg::row_t height,
	input  wire fsa_pkg::col_t width,
	input  wire fsa_pkg::pixel_t ref_data,

	input  wire s_axis_tvalid,
	input  wire fsa_pkg::pixel_t s_axis_tdata,
	input  wire s_axis_tuser,
	input  wire s_axis_tlast,
	output logic s_axis_tready,

	input  wire [fsa_pkg::reader_num-1:0] r_sof,
	input  wire [fsa_pkg::reader_num-1:0] r_en,
	input  wire [fsa_pkg::reader_num*fsa_pkg::col_w-1:0] r_addr,
	output logic [fsa_pkg::reader_num*fsa_pkg::word_w-1:0] r_data,

	output fsa_pkg::col_t lft_v,
	output fsa_pkg::col_t rt_v,
	output logic frame_done
);
	import fsa_pkg::*;

	logic px_valid;
	row_t px_row;
	col_t px_col;
	logic px_dark;
	logic px_eof;

	logic upd_rd_en;
	col_t upd_rd_addr;
	word_t upd_rd_data;
	logic upd_wr_en;
	col_t upd_wr_addr;
	word_t upd_wr_data;
	logic swap;

	// line length comes from tlast, width only describes the frame to the source
	fsa_pixel_decode decode_inst (
		.clk(clk),
		.resetn(resetn),
		.height(height),
		.ref_data(ref_data),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.px_valid(px_valid),
		.px_row(px_row),
		.px_col(px_col),
		.px_dark(px_dark),
		.px_eof(px_eof)
	);

	fsa_column_accum accum_inst (
		.clk(clk),
		.resetn(resetn),
		.px_valid(px_valid),
		.px_row(px_row),
		.px_col(px_col),
		.px_dark(px_dark),
		.px_eof(px_eof),
		.upd_rd_en(upd_rd_en),
		.upd_rd_addr(upd_rd_addr),
		.upd_rd_data(upd_rd_data),
		.upd_wr_en(upd_wr_en),
		.upd_wr_addr(upd_wr_addr),
		.upd_wr_data(upd_wr_data),
		.swap(swap),
		.lft_v(lft_v),
		.rt_v(rt_v),
		.frame_done(frame_done)
	);

	fsa_column_store store_inst (
		.clk(clk),
		.resetn(resetn),
		.upd_rd_en(upd_rd_en),
		.upd_rd_addr(upd_rd_addr),
		.upd_rd_data(upd_rd_data),
		.upd_wr_en(upd_wr_en),
		.upd_wr_addr(upd_wr_addr),
		.upd_wr_data(upd_wr_data),
		.swap(swap),
		.r_sof(r_sof),
		.r_en(r_en),
		.r_addr(r_addr),
		.r_data(r_data)
	);

endmodule

`default_nettype wire

// ==== hdl/fsa_column_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

module fsa_column_accum (
	input  wire clk,
	input  wire resetn,

	input  wire px_valid,
	input  wire fsa_pkg::row_t px_row,
	input  wire fsa_pkg::col_t px_col,
	input  wire px_dark,
	input  wire px_eof,

	output logic upd_rd_en,
	output fsa_pkg::col_t upd_rd_addr,
	input  wire fsa_pkg::word_t upd_rd_data,

	output logic upd_wr_en,
	output fsa_pkg::col_t upd_wr_addr,
	output fsa_pkg::word_t upd_wr_data,
	output logic swap,

	output fsa_pkg::col_t lft_v,
	output fsa_pkg::col_t rt_v,
	output logic frame_done
);
	import fsa_pkg::*;

	logic s1_valid;
	row_t s1_row;
	col_t s1_col;
	logic s1_dark;
	logic s1_eof;

	word_t old_word;
	row_t old_top;
	cnt_t old_cnt;
	word_t new_word;

	col_t cur_lft;
	col_t cur_rt;
	col_t base_lft;
	col_t base_rt;
	col_t nxt_lft;
	col_t nxt_rt;

	// stage one issues the read straight from the decode strobe
	assign upd_rd_en = px_valid;
	assign upd_rd_addr = px_col;

	always_ff @(posedge clk) begin
		if (!resetn)
			s1_valid <= 1'b0;
		else
			s1_valid <= px_valid;
	end

	always_ff @(posedge clk) begin
		s1_row <= px_row;
		s1_col <= px_col;
		s1_dark <= px_dark;
		s1_eof <= px_eof;
	end

	// row 0 starts every column afresh since the memory is never cleared
	assign old_word = (s1_row == '0) ? '0 : upd_rd_data;
	assign old_top = old_word[31:24];
	assign old_cnt = old_word[15:0];

	always_comb begin
		new_word = old_word;
		if (s1_dark) begin
			new_word[31:24] = (old_cnt == '0) ? s1_row : old_top;
			new_word[23:16] = s1_row;
			new_word[15:0] = old_cnt + 1'b1;
		end
	end

	// stage two writes the merged word and swap rides with the frame-end write
	always_ff @(posedge clk) begin
		if (!resetn) begin
			upd_wr_en <= 1'b0;
			swap <= 1'b0;
		end else begin
			upd_wr_en <= s1_valid;
			swap <= s1_valid & s1_eof;
		end
	end

	always_ff @(posedge clk) begin
		upd_wr_addr <= s1_col;
		upd_wr_data <= new_word;
	end

	// the first pixel of a frame drops the extent of the previous one
	always_comb begin
		base_lft = cur_lft;
		base_rt = cur_rt;
		if (s1_row == '0 && s1_col == '0) begin
			base_lft = '1;
			base_rt = '0;
		end
		nxt_lft = (s1_dark && s1_col < base_lft) ? s1_col : base_lft;
		nxt_rt = (s1_dark && s1_col > base_rt) ? s1_col : base_rt;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur_lft <= '1;
			cur_rt <= '0;
		end else if (s1_valid) begin
			cur_lft <= nxt_lft;
			cur_rt <= nxt_rt;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame_done <= 1'b0;
			lft_v <= '1;
			rt_v <= '0;
		end else begin
			frame_done <= swap;
			if (swap) begin
				lft_v <= cur_lft;
				rt_v <= cur_rt;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fsa_column_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module fsa_column_store (
	input  wire clk,
	input  wire resetn,

	input  wire upd_rd_en,
	input  wire fsa_pkg::col_t upd_rd_addr,
	output fsa_pkg::word_t upd_rd_data,

	input  wire upd_wr_en,
	input  wire fsa_pkg::col_t upd_wr_addr,
	input  wire fsa_pkg::word_t upd_wr_data,
	input  wire swap,

	input  wire [fsa_pkg::reader_num-1:0] r_sof,
	input  wire [fsa_pkg::reader_num-1:0] r_en,
	input  wire [fsa_pkg::reader_num*fsa_pkg::col_w-1:0] r_addr,
	output logic [fsa_pkg::reader_num*fsa_pkg::word_w-1:0] r_data
);
	import fsa_pkg::*;

	// both banks in one array, the bank bit is the top address bit
	word_t mem [0:(2 << col_w)-1];

	logic wr_bank;
	logic [reader_num-1:0] rd_bank;

	always_ff @(posedge clk) begin
		if (!resetn)
			wr_bank <= 1'b0;
		else if (swap)
			wr_bank <= ~wr_bank;
	end

	// the swap toggles the bank only after the frame-end word is written
	always_ff @(posedge clk) begin
		if (upd_wr_en)
			mem[{wr_bank, upd_wr_addr}] <= upd_wr_data;
	end

	// forward a write landing on the column being read, so that a
	// two-column frame still merges with the newest word
	always_ff @(posedge clk) begin
		if (upd_rd_en) begin
			if (upd_wr_en && upd_wr_addr == upd_rd_addr)
				upd_rd_data <= upd_wr_data;
			else
				upd_rd_data <= mem[{wr_bank, upd_rd_addr}];
		end
	end

	genvar i;
	generate
		for (i = 0; i < reader_num; i++) begin : g_lane
			col_t lane_addr;

			assign lane_addr = r_addr[i*col_w +: col_w];

			// the bank not being written is the last completed frame
			always_ff @(posedge clk) begin
				if (!resetn)
					rd_bank[i] <= 1'b1;
				else if (r_sof[i])
					rd_bank[i] <= ~wr_bank;
			end

			always_ff @(posedge clk) begin
				if (!resetn)
					r_data[i*word_w +: word_w] <= '0;
				else if (r_en[i])
					r_data[i*word_w +: word_w] <= mem[{rd_bank[i], lane_addr}];
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== hdl/fsa_pixel_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module fsa_pixel_decode (
	input  wire clk,
	input  wire resetn,

	input  wire fsa_pkg::row_t height,
	input  wire fsa_pkg::pixel_t ref_data,

	input  wire s_axis_tvalid,
	input  wire fsa_pkg::pixel_t s_axis_tdata,
	input  wire s_axis_tuser,
	input  wire s_axis_tlast,
	output logic s_axis_tready,

	output logic px_valid,
	output fsa_pkg::row_t px_row,
	output fsa_pkg::col_t px_col,
	output logic px_dark,
	output logic px_eof
);
	import fsa_pkg::*;

	row_t nxt_row;
	col_t nxt_col;
	row_t cur_row;
	col_t cur_col;
	logic accept;

	assign accept = s_axis_tvalid & s_axis_tready;

	// tuser restarts the frame at the origin whatever the counters say
	assign cur_row = s_axis_tuser ? '0 : nxt_row;
	assign cur_col = s_axis_tuser ? '0 : nxt_col;

	// the pipeline never stalls, so ready only waits for reset release
	always_ff @(posedge clk) begin
		if (!resetn)
			s_axis_tready <= 1'b0;
		else
			s_axis_tready <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			nxt_row <= '0;
			nxt_col <= '0;
		end else if (accept) begin
			if (s_axis_tlast) begin
				nxt_row <= cur_row + 1'b1;
				nxt_col <= '0;
			end else begin
				nxt_row <= cur_row;
				nxt_col <= cur_col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			px_valid <= 1'b0;
		else
			px_valid <= accept;
	end

	// a pixel equal to the reference is not dark
	always_ff @(posedge clk) begin
		if (accept) begin
			px_row <= cur_row;
			px_col <= cur_col;
			px_dark <= (s_axis_tdata < ref_data);
			px_eof <= s_axis_tlast && (cur_row == height - 1'b1);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fsa_pkg.sv ====
`default_nettype none

package fsa_pkg;

	// pixel and position widths
	localparam int pixel_w = 8;
	localparam int row_w = 8;
	localparam int col_w = 8;

	// a summary word holds top row, bottom row and the dark count
	localparam int word_w = 32;
	localparam int cnt_w = 16;

	// independent reader lanes on the summary memory
	localparam int reader_num = 2;

	// grayscale pixel value
	typedef logic [pixel_w-1:0] pixel_t;

	// row index or frame height
	typedef logic [row_w-1:0] row_t;

	// column index or frame width, also the memory address
	typedef logic [col_w-1:0] col_t;

	// bits 31..24 top row, 23..16 bottom row, 15..0 dark count
	typedef logic [word_w-1:0] word_t;

	// dark pixel count of one column
	typedef logic [cnt_w-1:0] cnt_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module test_fsa \
	-Mdir obj_dir -o sim_fsa > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_fsa +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

// ==== tb/fsa_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fsa_checker (
	input  wire clk,
	input  wire resetn,
	input  wire fsa_pkg::row_t height,
	input  wire fsa_pkg::pixel_t ref_data,
	input  wire s_axis_tvalid,
	input  wire s_axis_tready,
	input  wire fsa_pkg::pixel_t s_axis_tdata,
	input  wire s_axis_tuser,
	input  wire s_axis_tlast,
	input  wire [fsa_pkg::reader_num-1:0] r_sof,
	input  wire [fsa_pkg::reader_num-1:0] r_en,
	input  wire [fsa_pkg::reader_num*fsa_pkg::col_w-1:0] r_addr,
	input  wire [fsa_pkg::reader_num*fsa_pkg::word_w-1:0] r_data,
	input  wire fsa_pkg::col_t lft_v,
	input  wire fsa_pkg::col_t rt_v,
	input  wire frame_done,
	input  wire fsa_pkg::col_t exp_lft,
	input  wire fsa_pkg::col_t exp_rt,
	output int errors,
	output int checks
);
	import fsa_pkg::*;

	// expected words of the last two frames, slot is the frame index modulo 2
	word_t model [2][1 << col_w];
	row_t nxt_row;
	col_t nxt_col;
	int frame_idx;
	int done_count;
	int lane_frame [reader_num];
	logic [reader_num-1:0] pend;
	word_t pend_exp [reader_num];
	col_t pend_addr [reader_num];

	function automatic word_t merge_pixel(word_t old, logic dark, row_t row);
		word_t w;
		w = old;
		if (dark) begin
			if (old[15:0] == 16'd0)
				w[31:24] = row;
			w[23:16] = row;
			w[15:0] = old[15:0] + 16'd1;
		end
		return w;
	endfunction

	always @(posedge clk) begin : watch
		row_t row;
		col_t col;
		word_t old;
		word_t got;
		int i;
		if (!resetn) begin
			nxt_row = '0;
			nxt_col = '0;
			frame_idx = 0;
			done_count = 0;
			pend = '0;
			errors = 0;
			checks = 0;
			for (i = 0; i < reader_num; i++)
				lane_frame[i] = -1;
		end else begin
			if (s_axis_tvalid && s_axis_tready) begin
				row = s_axis_tuser ? '0 : nxt_row;
				col = s_axis_tuser ? '0 : nxt_col;
				old = (row == '0) ? '0 : model[frame_idx % 2][col];
				model[frame_idx % 2][col] = merge_pixel(old, s_axis_tdata < ref_data, row);
				nxt_row = s_axis_tlast ? row + 8'd1 : row;
				nxt_col = s_axis_tlast ? '0 : col + 8'd1;
				if (s_axis_tlast && row == height - 8'd1)
					frame_idx++;
			end
			if (frame_done) begin
				done_count++;
				checks += 2;
				if (lft_v !== exp_lft) begin
					errors++;
					$display("MISMATCH lft_v: got %h expected %h", lft_v, exp_lft);
				end
				if (rt_v !== exp_rt) begin
					errors++;
					$display("MISMATCH rt_v: got %h expected %h", rt_v, exp_rt);
				end
			end
			// a read issued on the previous edge shows up now
			for (i = 0; i < reader_num; i++) begin
				got = r_data[i*word_w +: word_w];
				if (pend[i]) begin
					checks++;
					if (got !== pend_exp[i]) begin
						errors++;
						$display("MISMATCH r_data[%0d] addr %h: got %h expected %h",
							i, pend_addr[i], got, pend_exp[i]);
					end
				end
				pend[i] = r_en[i] && lane_frame[i] >= 0;
				pend_addr[i] = r_addr[i*col_w +: col_w];
				if (pend[i])
					pend_exp[i] = model[lane_frame[i] % 2][pend_addr[i]];
				if (r_sof[i])
					lane_frame[i] = done_count - 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/fsa_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module fsa_sva (
	input  wire clk,
	input  wire resetn,
	input  wire s_axis_tready,
	input  wire frame_done,
	input  wire fsa_pkg::col_t lft_v,
	input  wire fsa_pkg::col_t rt_v,
	input  wire [fsa_pkg::reader_num-1:0] r_en,
	input  wire [fsa_pkg::reader_num*fsa_pkg::word_w-1:0] r_data
);
	import fsa_pkg::*;

	int fail_cnt = 0;

	ap_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
		frame_done |=> !frame_done)
	else begin
		fail_cnt++;
		$error("frame_done stayed high for more than one cycle");
	end

	// the extent only moves in the cycle that announces a finished frame
	ap_extent_hold: assert property (@(posedge clk) disable iff (!resetn)
		($changed(lft_v) || $changed(rt_v)) |-> frame_done)
	else begin
		fail_cnt++;
		$error("lft_v or rt_v changed without frame_done");
	end

	ap_ready_reset: assert property (@(posedge clk) !resetn |=> !s_axis_tready)
	else begin
		fail_cnt++;
		$error("s_axis_tready was high during reset");
	end

	genvar i;
	for (i = 0; i < reader_num; i++) begin : g_lane
		ap_data_hold: assert property (@(posedge clk) disable iff (!resetn)
			!$past(r_en[i]) |-> $stable(r_data[i*word_w +: word_w]))
		else begin
			fail_cnt++;
			$error("r_data lane %0d changed without a read", i);
		end
	end

endmodule

bind fsa fsa_sva sva_inst (
	.clk(clk),
	.resetn(resetn),
	.s_axis_tready(s_axis_tready),
	.frame_done(frame_done),
	.lft_v(lft_v),
	.rt_v(rt_v),
	.r_en(r_en),
	.r_data(r_data)
);

`default_nettype wire

// ==== tb/test_fsa.sv ====
`timescale 1ns/10ps
`default_nettype none

module test_fsa;
	import fsa_pkg::*;

	localparam int frame_num = 5;

	// one frame: size, reference, two rectangles (rows, columns, value), expected extent
	typedef struct packed {
		int h;
		int w;
		int ref_lvl;
		int a_r0, a_r1, a_c0, a_c1, a_val;
		int b_r0, b_r1, b_c0, b_c1, b_val;
		int lft;
		int rt;
	} frame_t;

	frame_t tbl [frame_num];
	int limit = 0;
	int seed = 30;
	int done_seen = 0;
	int errors;
	int checks;

	logic clk;
	logic resetn;
	row_t height;
	col_t width;
	pixel_t ref_data;
	logic s_axis_tvalid;
	pixel_t s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tready;
	logic [reader_num-1:0] r_sof;
	logic [reader_num-1:0] r_en;
	logic [reader_num*col_w-1:0] r_addr;
	logic [reader_num*word_w-1:0] r_data;
	col_t lft_v;
	col_t rt_v;
	logic frame_done;
	col_t exp_lft;
	col_t exp_rt;

	fsa fsa_inst (
		.clk(clk),
		.resetn(resetn),
		.height(height),
		.width(width),
		.ref_data(ref_data),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.r_sof(r_sof),
		.r_en(r_en),
		.r_addr(r_addr),
		.r_data(r_data),
		.lft_v(lft_v),
		.rt_v(rt_v),
		.frame_done(frame_done)
	);

	fsa_checker checker_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		if (resetn && frame_done)
			done_seen <= done_seen + 1;

	function automatic pixel_t pixel_at(int f, int r, int c);
		pixel_t v;
		v = pixel_t'(128 + c);
		if (r >= tbl[f].a_r0 && r <= tbl[f].a_r1 && c >= tbl[f].a_c0 && c <= tbl[f].a_c1)
			v = pixel_t'(tbl[f].a_val);
		if (r >= tbl[f].b_r0 && r <= tbl[f].b_r1 && c >= tbl[f].b_c0 && c <= tbl[f].b_c1)
			v = pixel_t'(tbl[f].b_val);
		return v;
	endfunction

	// called 2 ns after an edge, returns 2 ns after the edge that took the beat
	task automatic send_pixel(input pixel_t data, input logic first, input logic line_end);
		while (!s_axis_tready || (($random(seed) & 3) == 0)) begin
			s_axis_tvalid = 1'b0;
			@(posedge clk);
			#2;
		end
		s_axis_tvalid = 1'b1;
		s_axis_tdata = data;
		s_axis_tuser = first;
		s_axis_tlast = line_end;
		@(posedge clk);
		#2;
		s_axis_tvalid = 1'b0;
	endtask

	task automatic stream_frame(input int f);
		int r;
		int c;
		for (r = 0; r < tbl[f].h; r++)
			for (c = 0; c < tbl[f].w; c++)
				send_pixel(pixel_at(f, r, c), r == 0 && c == 0, c == tbl[f].w - 1);
	endtask

	// lane 0 walks up while lane 1 walks down
	task automatic sweep_columns(input int w);
		int c;
		for (c = 0; c < w; c++) begin
			r_en = '1;
			r_addr = {col_t'(w - 1 - c), col_t'(c)};
			@(posedge clk);
			#2;
		end
		r_en = '0;
		@(posedge clk);
		#2;
	endtask

	task automatic latch_newest;
		r_sof = '1;
		@(posedge clk);
		#2;
		r_sof = '0;
	endtask

	task automatic wait_frames(input int target);
		while (done_seen < target) begin
			@(posedge clk);
			#2;
		end
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no result after %0d cycles, the run hung", cycles);
		$display("Result: FAILED");
		$finish;
	end

	initial begin : main
		int f;
		int pixels;
		resetn = 1'b0;
		height = '0;
		width = '0;
		ref_data = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		r_sof = '0;
		r_en = '0;
		r_addr = '0;
		exp_lft = '1;
		exp_rt = '0;
		tbl[0] = '{16, 23, 100, 5, 7, 0, 17, 20, 10, 15, 0, 17, 40, 0, 17};
		tbl[1] = '{8, 10, 100, 0, 7, 0, 9, 100, 2, 3, 4, 5, 230, 255, 0};
		tbl[2] = '{12, 20, 150, 2, 4, 3, 6, 150, 7, 9, 10, 12, 250, 0, 19};
		tbl[3] = '{6, 2, 129, 3, 4, 1, 1, 0, 0, 0, 0, 0, 255, 0, 1};
		tbl[4] = '{10, 32, 60, 1, 2, 7, 9, 10, 4, 8, 25, 27, 59, 7, 27};
		pixels = 0;
		for (f = 0; f < frame_num; f++)
			pixels += tbl[f].h * tbl[f].w;
		limit = 4 * pixels + 2000;
		repeat (2) @(posedge clk);
		#2;
		resetn = 1'b1;
		for (f = 0; f < frame_num; f++) begin
			height = row_t'(tbl[f].h);
			width = col_t'(tbl[f].w);
			ref_data = pixel_t'(tbl[f].ref_lvl);
			exp_lft = col_t'(tbl[f].lft);
			exp_rt = col_t'(tbl[f].rt);
			// the lanes still hold the previous frame while this one is written
			fork
				stream_frame(f);
				if (f > 0)
					sweep_columns(tbl[f-1].w);
			join
			wait_frames(f + 1);
			if (f > 0)
				sweep_columns(tbl[f-1].w);
			latch_newest();
			sweep_columns(tbl[f].w);
		end
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, fsa_inst.sva_inst.fail_cnt);
		if (errors == 0 && fsa_inst.sva_inst.fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/fsa_pkg.sv
hdl/fsa_pixel_decode.sv
hdl/fsa_column_accum.sv
hdl/fsa_column_store.sv
hdl/fsa.sv
tb/fsa_sva.sv
tb/fsa_checker.sv
tb/test_fsa.sv
